// File: Makefile
# Verilator simulation of the configuration register block

VERILATOR ?= verilator
TOP       ?= tb_cw_io
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/cw_io_pkg.sv
package cw_io_pkg;

   import cw_reg_pkg::*;                         // aux_cfg_t is part of io_cfg_t

   typedef logic [3:0] pin_vec_t;                // one bit per target pin, pin 1 at bit 0
   typedef logic [5:0] trig_in_t;                // fa fb r1 r2 r3 r4 at bits 0 to 5

   // one routing byte per target pin
   typedef struct packed {
      logic gpio_enable;                         // bit 7
      logic gpio_level;
      logic tx_open_collector;                   // pin 3 only
      logic usi_open_collector;                  // pin 3 only
      logic usi_in;
      logic usi_out;
      logic rx;
      logic tx;                                  // bit 0
   } pin_route_t;

   typedef struct packed {
      aux_cfg_t         aux;                     // bytes 5 and 6 of the routing register
      pin_route_t [3:0] pin;                     // bytes 0 to 3, pin 1 at index 0
   } io_cfg_t;

endpackage

// File: source/cw_io_top.sv
module cw_io_top
   import cw_reg_pkg::*;
   import cw_io_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  reg_addr_t addr_i,
   input  byte_cnt_t byte_cnt_i,
   input  reg_byte_t data_i,
   input  logic      reg_read_i,
   input  logic      reg_write_i,
   input  logic      addr_valid_i,
   input  reg_addr_t hyp_addr_i,
   output reg_byte_t data_o,
   output reg_len_t  reg_len_o,
   input  trig_in_t  trig_in_i,                  // fa fb r1 r2 r3 r4
   input  logic      trig_advio_i,
   input  logic      trig_anapattern_i,
   input  logic      trig_decodedio_i,
   output logic      trigger_ext_o,
   output logic      trigger_o,
   input  logic      uart_tx_i,
   input  logic      usi_out_i,
   input  pin_vec_t  targetio_i,
   output pin_vec_t  targetio_o,
   output pin_vec_t  targetio_oe_o,
   output logic      uart_rx_o,
   output logic      usi_in_o,
   output logic      targetpower_off_o,
   output logic      enable_avrprog_o,
   output logic      enable_nrst_o,
   output logic      nrst_o,
   output logic      enable_pdid_o,
   output logic      pdid_o,
   output logic      enable_pdic_o,
   output logic      pdic_o
);

   trig_cfg_t trig_cfg;                          // register file to trigger path
   io_cfg_t   io_cfg;                            // register file to router
   pin_vec_t  pin_level;                         // router back to readback

   cw_reg_file u_reg_file (
      .clk          (clk),
      .reset        (reset),
      .addr_i       (addr_i),
      .byte_cnt_i   (byte_cnt_i),
      .data_i       (data_i),
      .reg_read_i   (reg_read_i),
      .reg_write_i  (reg_write_i),
      .addr_valid_i (addr_valid_i),
      .hyp_addr_i   (hyp_addr_i),
      .pin_level_i  (pin_level),
      .data_o       (data_o),
      .reg_len_o    (reg_len_o),
      .trig_cfg_o   (trig_cfg),
      .io_cfg_o     (io_cfg)
   );

   trigger_path u_trigger_path (
      .trig_cfg_i        (trig_cfg),
      .trig_in_i         (trig_in_i),
      .trig_advio_i      (trig_advio_i),
      .trig_anapattern_i (trig_anapattern_i),
      .trig_decodedio_i  (trig_decodedio_i),
      .trigger_ext_o     (trigger_ext_o),
      .trigger_o         (trigger_o)
   );

   target_io_router u_io_router (
      .clk               (clk),
      .reset             (reset),
      .io_cfg_i          (io_cfg),
      .uart_tx_i         (uart_tx_i),
      .usi_out_i         (usi_out_i),
      .targetio_i        (targetio_i),
      .targetio_o        (targetio_o),
      .targetio_oe_o     (targetio_oe_o),
      .pin_level_o       (pin_level),
      .uart_rx_o         (uart_rx_o),
      .usi_in_o          (usi_in_o),
      .targetpower_off_o (targetpower_off_o),
      .enable_avrprog_o  (enable_avrprog_o),
      .enable_nrst_o     (enable_nrst_o),
      .nrst_o            (nrst_o),
      .enable_pdid_o     (enable_pdid_o),
      .pdid_o            (pdid_o),
      .enable_pdic_o     (enable_pdic_o),
      .pdic_o            (pdic_o)
   );

endmodule

// File: source/cw_reg_file.sv
module cw_reg_file
   import cw_reg_pkg::*;
   import cw_io_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  reg_addr_t addr_i,                     // address of the current access
   input  byte_cnt_t byte_cnt_i,                 // byte index within the access
   input  reg_byte_t data_i,                     // write data
   input  logic      reg_read_i,                 // read strobe
   input  logic      reg_write_i,                // write strobe
   input  logic      addr_valid_i,
   input  reg_addr_t hyp_addr_i,                 // address for the length lookup
   input  pin_vec_t  pin_level_i,                // sampled pin levels from the router
   output reg_byte_t data_o,
   output reg_len_t  reg_len_o,
   output trig_cfg_t trig_cfg_o,
   output io_cfg_t   io_cfg_o
);

   reg_byte_t        trigsrc_q;
   reg_byte_t        trigmod_q;
   pin_route_t [3:0] pin_route_q;                // routing bytes 0 to 3
   reg_byte_t        extra_q;                    // routing byte 5
   reg_byte_t        extra_gpio_q;               // routing byte 6
   reg_byte_t        rd_next;
   reg_byte_t        rd_data_q;
   logic             rd_valid_q;
   logic             addr_known;

   always_ff @(posedge clk) begin
      if (reset) begin
         trigsrc_q    <= TRIGSRC_RESET;
         trigmod_q    <= TRIGMOD_RESET;
         pin_route_q  <= IOROUTE_RESET[31:0];
         extra_q      <= IOROUTE_RESET[47:40];
         extra_gpio_q <= IOROUTE_RESET[55:48];
      end else if (reg_write_i) begin
         case (addr_i)
            TRIGSRC_ADDR: trigsrc_q <= data_i;
            TRIGMOD_ADDR: trigmod_q <= data_i;
            IOROUTE_ADDR: begin
               case (byte_cnt_i)
                  16'd0, 16'd1, 16'd2, 16'd3: pin_route_q[byte_cnt_i[1:0]] <= data_i;
                  16'd5: extra_q <= data_i;
                  16'd6: extra_gpio_q <= data_i;
                  default: ;                     // glitch and reserved bytes dropped
               endcase
            end
            default: ;                           // ioread is read only
         endcase
      end
   end

   always_comb begin
      addr_known = (addr_i == TRIGSRC_ADDR) || (addr_i == TRIGMOD_ADDR) ||
                   (addr_i == IOROUTE_ADDR) || (addr_i == IOREAD_ADDR);
   end

   // readback mux, registered on the read strobe
   always_comb begin
      rd_next = '0;
      case (addr_i)
         TRIGSRC_ADDR: rd_next = trigsrc_q;
         TRIGMOD_ADDR: rd_next = trigmod_q;
         IOROUTE_ADDR: begin
            case (byte_cnt_i)
               16'd0, 16'd1, 16'd2, 16'd3: rd_next = pin_route_q[byte_cnt_i[1:0]];
               16'd5: rd_next = extra_q;
               16'd6: rd_next = extra_gpio_q;
               default: rd_next = '0;            // bytes 4, 7 and beyond read zero
            endcase
         end
         IOREAD_ADDR: rd_next = {4'b0000, pin_level_i};
         default: rd_next = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reg_read_i) rd_data_q <= rd_next;
   end

   always_ff @(posedge clk) begin
      if (reset) rd_valid_q <= 1'b0;
      else       rd_valid_q <= addr_valid_i && addr_known;
   end

   assign data_o = rd_valid_q ? rd_data_q : '0;

   always_comb begin
      case (hyp_addr_i)
         TRIGSRC_ADDR: reg_len_o = TRIGSRC_LEN;
         TRIGMOD_ADDR: reg_len_o = TRIGMOD_LEN;
         IOROUTE_ADDR: reg_len_o = IOROUTE_LEN;
         IOREAD_ADDR:  reg_len_o = IOREAD_LEN;
         default:      reg_len_o = '0;
      endcase
   end

   assign trig_cfg_o.mode       = trigsrc_q[7:6];
   assign trig_cfg_o.src_mask   = trigsrc_q[5:0];
   assign trig_cfg_o.module_sel = trigmod_q[2:0];

   assign io_cfg_o.pin            = pin_route_q;
   assign io_cfg_o.aux.avrprog_en = extra_q[0];
   assign io_cfg_o.aux.power_off  = extra_q[1];
   assign io_cfg_o.aux.nrst_en    = extra_gpio_q[0];
   assign io_cfg_o.aux.nrst_val   = extra_gpio_q[1];
   assign io_cfg_o.aux.pdid_en    = extra_gpio_q[2];
   assign io_cfg_o.aux.pdid_val   = extra_gpio_q[3];
   assign io_cfg_o.aux.pdic_en    = extra_gpio_q[4];
   assign io_cfg_o.aux.pdic_val   = extra_gpio_q[5];

   // host side never reads and writes in the same cycle
   a_no_rd_wr: assert property (@(posedge clk) disable iff (reset)
      !(reg_read_i && reg_write_i));

endmodule

// File: source/cw_reg_pkg.sv
package cw_reg_pkg;

   typedef logic [5:0]  reg_addr_t;              // register address on the byte port
   typedef logic [7:0]  reg_byte_t;              // one data byte
   typedef logic [15:0] byte_cnt_t;              // byte index inside a multi-byte access
   typedef logic [15:0] reg_len_t;               // register length in bytes

   localparam reg_addr_t TRIGSRC_ADDR = 6'd39;   // trigger source mask and combine mode
   localparam reg_addr_t TRIGMOD_ADDR = 6'd40;   // trigger module select
   localparam reg_addr_t IOROUTE_ADDR = 6'd55;   // target i/o routing, 8 bytes
   localparam reg_addr_t IOREAD_ADDR  = 6'd59;   // pin readback

   localparam reg_len_t TRIGSRC_LEN = 16'd1;
   localparam reg_len_t TRIGMOD_LEN = 16'd1;
   localparam reg_len_t IOROUTE_LEN = 16'd8;
   localparam reg_len_t IOREAD_LEN  = 16'd1;

   localparam reg_byte_t TRIGSRC_RESET = 8'h20;  // or mode, source r4 only
   localparam reg_byte_t TRIGMOD_RESET = 8'h00;  // normal edge trigger
   // uart tx on pin 1, uart rx on pin 2, everything else off
   localparam logic [63:0] IOROUTE_RESET = 64'h0000_0000_0000_0201;

   typedef struct packed {
      logic [1:0] mode;                          // 0 or, 1 and, 2 nand, 3 off
      logic [5:0] src_mask;                      // r4 r3 r2 r1 fb fa
      logic [2:0] module_sel;                    // final trigger source
   } trig_cfg_t;

   typedef struct packed {
      logic avrprog_en;                          // avr programming lines to the sam3u
      logic power_off;                           // target power disable
      logic nrst_en;                             // nrst as gpio
      logic nrst_val;
      logic pdid_en;                             // pdid as gpio
      logic pdid_val;
      logic pdic_en;                             // pdic as gpio
      logic pdic_val;
   } aux_cfg_t;

endpackage

// File: source/target_io_router.sv
module target_io_router
   import cw_io_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  io_cfg_t  io_cfg_i,
   input  logic     uart_tx_i,
   input  logic     usi_out_i,
   input  pin_vec_t targetio_i,                  // pad input levels
   output pin_vec_t targetio_o,                  // pad output values
   output pin_vec_t targetio_oe_o,               // pad output enables
   output pin_vec_t pin_level_o,                 // levels sampled last edge
   output logic     uart_rx_o,
   output logic     usi_in_o,
   output logic     targetpower_off_o,
   output logic     enable_avrprog_o,
   output logic     enable_nrst_o,
   output logic     nrst_o,
   output logic     enable_pdid_o,
   output logic     pdid_o,
   output logic     enable_pdic_o,
   output logic     pdic_o
);

   logic     power_off_q;
   pin_vec_t drv_oe;                             // enables before the power-off force
   pin_vec_t level;                              // observed pin level
   pin_vec_t pin_level_q;

   always_ff @(posedge clk) begin
      if (reset) power_off_q <= 1'b0;
      else       power_off_q <= io_cfg_i.aux.power_off;
   end

   // per-pin drive, highest priority first
   always_comb begin
      pin_route_t r;
      for (int i = 0; i < 4; i++) begin
         r = io_cfg_i.pin[i];
         targetio_o[i] = 1'b0;
         drv_oe[i]     = 1'b0;
         if (r.tx) begin
            targetio_o[i] = uart_tx_i;
            drv_oe[i]     = 1'b1;
         end else if (r.usi_out && i != 3) begin      // pin 4 has no usi
            targetio_o[i] = usi_out_i;
            drv_oe[i]     = 1'b1;
         end else if (r.usi_open_collector && i == 2) begin
            drv_oe[i] = ~usi_out_i;                   // pull low only
         end else if (r.tx_open_collector && i == 2) begin
            drv_oe[i] = ~uart_tx_i;
         end else if (r.gpio_enable) begin
            targetio_o[i] = r.gpio_level;
            drv_oe[i]     = 1'b1;
         end
      end
   end

   assign targetio_oe_o = power_off_q ? '0 : drv_oe;  // all high-z with target unpowered
   assign level = (targetio_oe_o & targetio_o) | (~targetio_oe_o & targetio_i);

   // lowest numbered pin wins, idle high otherwise
   always_comb begin
      uart_rx_o = 1'b1;
      usi_in_o  = 1'b1;
      for (int i = 3; i >= 0; i--) begin
         if (io_cfg_i.pin[i].rx) uart_rx_o = level[i];
         if (i < 3 && io_cfg_i.pin[i].usi_in) usi_in_o = level[i];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) pin_level_q <= '0;
      else       pin_level_q <= level;
   end

   assign pin_level_o       = pin_level_q;
   assign targetpower_off_o = power_off_q;
   assign enable_avrprog_o  = io_cfg_i.aux.avrprog_en;
   assign enable_nrst_o     = io_cfg_i.aux.nrst_en;
   assign nrst_o            = io_cfg_i.aux.nrst_val;
   assign enable_pdid_o     = io_cfg_i.aux.pdid_en;
   assign pdid_o            = io_cfg_i.aux.pdid_val;
   assign enable_pdic_o     = io_cfg_i.aux.pdic_en;
   assign pdic_o            = io_cfg_i.aux.pdic_val;

   // a power-off request has released every pin by the next edge
   a_off_highz: assert property (@(posedge clk) disable iff (reset)
      io_cfg_i.aux.power_off |=> (targetio_oe_o == '0));

endmodule

// File: source/trigger_path.sv
module trigger_path
   import cw_reg_pkg::*;
   import cw_io_pkg::*;
(
   input  trig_cfg_t trig_cfg_i,
   input  trig_in_t  trig_in_i,                  // external trigger lines
   input  logic      trig_advio_i,               // advanced io pattern trigger
   input  logic      trig_anapattern_i,          // sad trigger
   input  logic      trig_decodedio_i,           // decoded io trigger
   output logic      trigger_ext_o,              // combined external trigger
   output logic      trigger_o                   // final trigger to capture
);

   logic masked_or;
   logic masked_and;

   assign masked_or  = |(trig_cfg_i.src_mask & trig_in_i);
   assign masked_and = &(~trig_cfg_i.src_mask | trig_in_i);  // disabled lines count as 1

   always_comb begin
      case (trig_cfg_i.mode)
         2'd0:    trigger_ext_o = masked_or;
         2'd1:    trigger_ext_o = masked_and;
         2'd2:    trigger_ext_o = ~masked_and;
         default: trigger_ext_o = 1'b0;
      endcase
   end

   always_comb begin
      case (trig_cfg_i.module_sel)
         3'd0:    trigger_o = trigger_ext_o;
         3'd1:    trigger_o = trig_advio_i;
         3'd2:    trigger_o = trig_anapattern_i;
         3'd3:    trigger_o = trig_decodedio_i;
         default: trigger_o = 1'b0;               // unused selects park low
      endcase
   end

endmodule

// File: sources.f
+incdir+testbench
source/cw_reg_pkg.sv
source/cw_io_pkg.sv
source/cw_reg_file.sv
source/trigger_path.sv
source/target_io_router.sv
source/cw_io_top.sv
testbench/tb_cw_io.sv

// File: testbench/tb_cw_io_tests.svh
// register lengths from the register map
function automatic reg_len_t exp_len(input reg_addr_t a);
   case (a)
      6'd39, 6'd40, 6'd59: return 16'd1;
      6'd55:               return 16'd8;         // routing block
      default:             return 16'd0;
   endcase
endfunction

function automatic logic exp_combined(input logic [1:0] mode, input logic [5:0] mask,
                                      input logic [5:0] lines);
   logic any_hi;
   logic all_hi;
   any_hi = 1'b0;
   all_hi = 1'b1;                                // empty mask leaves and at 1
   for (int i = 0; i < 6; i++) begin
      if (mask[i]) begin
         if (lines[i]) any_hi = 1'b1;
         else          all_hi = 1'b0;
      end
   end
   case (mode)
      2'd0:    return any_hi;
      2'd1:    return all_hi;
      2'd2:    return ~all_hi;
      default: return 1'b0;
   endcase
endfunction

function automatic logic exp_trigger(input logic [2:0] sel, input logic ext, input logic advio,
                                     input logic ana, input logic dec);
   case (sel)
      3'd0:    return ext;
      3'd1:    return advio;
      3'd2:    return ana;
      3'd3:    return dec;
      default: return 1'b0;
   endcase
endfunction

// pin drive by priority, returns {enable, value}, p counts from 0 for pin 1
function automatic logic [1:0] exp_pin(input int p, input reg_byte_t r, input logic tx,
                                       input logic usi);
   if (r[0]) return {1'b1, tx};                  // uart tx first
   if (r[2] && p != 3) return {1'b1, usi};       // no usi on pin 4
   if (r[4] && p == 2) return {~usi, 1'b0};      // open collector, pulls low only
   if (r[5] && p == 2) return {~tx, 1'b0};
   if (r[7]) return {1'b1, r[6]};                // plain gpio
   return 2'b00;
endfunction

task automatic test_reset_values();
   int        err0;
   reg_byte_t rd;
   err0 = errors;
   check_value("targetpower_off_o", 16'(targetpower_off_o), 16'h0);
   check_value("targetio_oe_o", 16'(targetio_oe_o), 16'h1);  // pin 1 carries tx
   check_value("data_o", 16'(data_o), 16'h0);
   do_read(IOREAD_ADDR, 16'd0, 1'b1, rd);
   check_value("data_o ioread", 16'(rd), 16'h00);
   do_read(TRIGSRC_ADDR, 16'd0, 1'b1, rd);
   check_value("data_o trigsrc", 16'(rd), 16'h20);
   do_read(TRIGMOD_ADDR, 16'd0, 1'b1, rd);
   check_value("data_o trigmod", 16'(rd), 16'h00);
   for (int b = 0; b < 8; b++) begin
      do_read(IOROUTE_ADDR, byte_cnt_t'(b), 1'b1, rd);
      check_value("data_o ioroute", 16'(rd), (b == 0) ? 16'h01 : (b == 1) ? 16'h02 : 16'h00);
   end
   do_read(TRIGSRC_ADDR, 16'd0, 1'b0, rd);      // address not valid
   check_value("data_o invalid", 16'(rd), 16'h00);
   for (int a = 0; a < 64; a++) begin
      hyp_addr_i = reg_addr_t'(a);
      next_slot();
      check_value("reg_len_o", reg_len_o, exp_len(reg_addr_t'(a)));
   end
   report_test("reset_values", err0);
endtask

task automatic test_register_readback();
   int        err0;
   reg_byte_t rd;
   reg_byte_t src;
   reg_byte_t mod;
   reg_byte_t route [8];
   err0 = errors;
   src = lcg_byte();
   mod = lcg_byte();
   do_write(TRIGSRC_ADDR, 16'd0, src);
   do_write(TRIGMOD_ADDR, 16'd0, mod);
   for (int b = 0; b < 8; b++) begin
      route[b] = lcg_byte();
      do_write(IOROUTE_ADDR, byte_cnt_t'(b), route[b]);
   end
   do_read(TRIGSRC_ADDR, 16'd0, 1'b1, rd);
   check_value("data_o trigsrc", 16'(rd), 16'(src));
   do_read(TRIGMOD_ADDR, 16'd0, 1'b1, rd);
   check_value("data_o trigmod", 16'(rd), 16'(mod));
   for (int b = 0; b < 8; b++) begin
      do_read(IOROUTE_ADDR, byte_cnt_t'(b), 1'b1, rd);
      check_value("data_o ioroute", 16'(rd), (b == 4 || b == 7) ? 16'h00 : 16'(route[b]));
   end
   report_test("register_readback", err0);
endtask

task automatic test_trigger_combine();
   int        err0;
   reg_byte_t src;
   reg_byte_t mod;
   reg_byte_t stim;
   logic      ext;
   err0 = errors;
   for (int n = 0; n < 40; n++) begin
      src = lcg_byte();
      mod = lcg_byte();
      if (n[0]) mod[2:0] = 3'd0;                 // half the rounds see the combined trigger
      do_write(TRIGSRC_ADDR, 16'd0, src);
      do_write(TRIGMOD_ADDR, 16'd0, mod);
      for (int k = 0; k < 3; k++) begin
         stim              = lcg_byte();
         trig_in_i         = stim[5:0];
         stim              = lcg_byte();
         trig_advio_i      = stim[0];
         trig_anapattern_i = stim[1];
         trig_decodedio_i  = stim[2];
         next_slot();
         ext = exp_combined(src[7:6], src[5:0], trig_in_i);
         check_value("trigger_ext_o", 16'(trigger_ext_o), 16'(ext));
         check_value("trigger_o", 16'(trigger_o), 16'(exp_trigger(mod[2:0], ext,
                     trig_advio_i, trig_anapattern_i, trig_decodedio_i)));
      end
   end
   report_test("trigger_combine", err0);
endtask

task automatic test_pin_drive();
   int         err0;
   reg_byte_t  route [4];
   reg_byte_t  aux5;
   reg_byte_t  aux6;
   logic [1:0] pin;
   pin_vec_t   exp_oe;
   pin_vec_t   exp_out;
   err0 = errors;
   for (int n = 0; n < 16; n++) begin
      for (int p = 0; p < 4; p++) begin
         route[p] = lcg_byte();
         if (n[0]) route[p] = route[p] & 8'hfa;  // drop tx and usi_out, open collector shows
      end
      if (n[0]) route[2][5:4] = n[1] ? 2'b10 : 2'b01;  // usi and tx open collector in turn
      aux5 = lcg_byte() & 8'h01;                 // avrprog only, target stays powered
      aux6 = lcg_byte();
      for (int p = 0; p < 4; p++) begin
         do_write(IOROUTE_ADDR, byte_cnt_t'(p), route[p]);
      end
      do_write(IOROUTE_ADDR, 16'd5, aux5);
      do_write(IOROUTE_ADDR, 16'd6, aux6);
      for (int k = 0; k < 4; k++) begin
         uart_tx_i = k[0];
         usi_out_i = k[1];
         next_slot();
         for (int p = 0; p < 4; p++) begin
            pin        = exp_pin(p, route[p], uart_tx_i, usi_out_i);
            exp_oe[p]  = pin[1];
            exp_out[p] = pin[0];
         end
         check_value("targetio_oe_o", 16'(targetio_oe_o), 16'(exp_oe));
         check_value("targetio_o", 16'(targetio_o & exp_oe), 16'(exp_out & exp_oe));
      end
      check_value("enable_avrprog_o", 16'(enable_avrprog_o), 16'(aux5[0]));
      check_value("enable_nrst_o", 16'(enable_nrst_o), 16'(aux6[0]));
      check_value("nrst_o", 16'(nrst_o), 16'(aux6[1]));
      check_value("enable_pdid_o", 16'(enable_pdid_o), 16'(aux6[2]));
      check_value("pdid_o", 16'(pdid_o), 16'(aux6[3]));
      check_value("enable_pdic_o", 16'(enable_pdic_o), 16'(aux6[4]));
      check_value("pdic_o", 16'(pdic_o), 16'(aux6[5]));
   end
   report_test("pin_drive", err0);
endtask

task automatic test_input_routing();
   int         err0;
   reg_byte_t  route [4];
   reg_byte_t  stim;
   reg_byte_t  rd;
   logic [1:0] pin;
   pin_vec_t   lvl;
   logic       exp_rx;
   logic       exp_usi;
   logic       rx_found;
   logic       usi_found;
   err0 = errors;
   do_write(IOROUTE_ADDR, 16'd5, 8'h00);        // target powered
   for (int n = 0; n < 20; n++) begin
      for (int p = 0; p < 4; p++) begin
         route[p] = lcg_byte();
         if (n % 4 == 0) route[p] = route[p] & 8'hf5;  // nothing selected, both idle high
         do_write(IOROUTE_ADDR, byte_cnt_t'(p), route[p]);
      end
      stim       = lcg_byte();
      targetio_i = stim[3:0];
      uart_tx_i  = stim[4];
      usi_out_i  = stim[5];
      next_slot();
      exp_rx    = 1'b1;
      exp_usi   = 1'b1;
      rx_found  = 1'b0;
      usi_found = 1'b0;
      for (int p = 0; p < 4; p++) begin
         pin    = exp_pin(p, route[p], uart_tx_i, usi_out_i);
         lvl[p] = pin[1] ? pin[0] : targetio_i[p];  // driven pins read back their own value
         if (route[p][1] && !rx_found) begin
            exp_rx   = lvl[p];
            rx_found = 1'b1;
         end
         if (p < 3 && route[p][3] && !usi_found) begin
            exp_usi   = lvl[p];
            usi_found = 1'b1;
         end
      end
      check_value("uart_rx_o", 16'(uart_rx_o), 16'(exp_rx));
      check_value("usi_in_o", 16'(usi_in_o), 16'(exp_usi));
      do_read(IOREAD_ADDR, 16'd0, 1'b1, rd);
      check_value("data_o ioread", 16'(rd), 16'({4'b0000, lvl}));
   end
   report_test("input_routing", err0);
endtask

task automatic test_power_off();
   int         err0;
   reg_byte_t  route [4];
   logic [1:0] pin;
   pin_vec_t   exp_oe;
   pin_vec_t   exp_out;
   err0 = errors;
   route[0]  = 8'h01;                            // tx
   route[1]  = 8'hc0;                            // gpio high
   route[2]  = 8'h04;                            // usi out
   route[3]  = 8'h80;                            // gpio low
   uart_tx_i = 1'b1;
   usi_out_i = 1'b0;
   do_write(IOROUTE_ADDR, 16'd5, 8'h00);
   for (int p = 0; p < 4; p++) begin
      do_write(IOROUTE_ADDR, byte_cnt_t'(p), route[p]);
      pin        = exp_pin(p, route[p], uart_tx_i, usi_out_i);
      exp_oe[p]  = pin[1];
      exp_out[p] = pin[0];
   end
   check_value("targetio_oe_o", 16'(targetio_oe_o), 16'(exp_oe));
   check_value("targetpower_off_o", 16'(targetpower_off_o), 16'h0);
   do_write(IOROUTE_ADDR, 16'd5, 8'h02);        // power-off bit
   check_value("targetpower_off_o", 16'(targetpower_off_o), 16'h0);  // one cycle behind
   check_value("targetio_oe_o", 16'(targetio_oe_o), 16'(exp_oe));
   next_slot();
   check_value("targetpower_off_o", 16'(targetpower_off_o), 16'h1);
   check_value("targetio_oe_o", 16'(targetio_oe_o), 16'h0);
   do_write(IOROUTE_ADDR, 16'd5, 8'h00);
   check_value("targetpower_off_o", 16'(targetpower_off_o), 16'h1);
   check_value("targetio_oe_o", 16'(targetio_oe_o), 16'h0);
   next_slot();
   check_value("targetpower_off_o", 16'(targetpower_off_o), 16'h0);
   check_value("targetio_oe_o", 16'(targetio_oe_o), 16'(exp_oe));
   check_value("targetio_o", 16'(targetio_o & exp_oe), 16'(exp_out & exp_oe));
   report_test("power_off", err0);
endtask

// File: testbench/tb_cw_io.sv
module tb_cw_io
   import cw_reg_pkg::*;
   import cw_io_pkg::*;
();

   localparam int NUM_TESTS   = 6;
   localparam int TEST_CYCLES = 400;             // cycle budget of one test
   localparam int CLK_PERIOD  = 40;

   logic        clk = 1'b0;
   logic        reset;
   reg_addr_t   addr_i;
   byte_cnt_t   byte_cnt_i;
   reg_byte_t   data_i;
   logic        reg_read_i;
   logic        reg_write_i;
   logic        addr_valid_i;
   reg_addr_t   hyp_addr_i;
   reg_byte_t   data_o;
   reg_len_t    reg_len_o;
   trig_in_t    trig_in_i;
   logic        trig_advio_i;
   logic        trig_anapattern_i;
   logic        trig_decodedio_i;
   logic        trigger_ext_o;
   logic        trigger_o;
   logic        uart_tx_i;
   logic        usi_out_i;
   pin_vec_t    targetio_i;
   pin_vec_t    targetio_o;
   pin_vec_t    targetio_oe_o;
   logic        uart_rx_o;
   logic        usi_in_o;
   logic        targetpower_off_o;
   logic        enable_avrprog_o;
   logic        enable_nrst_o;
   logic        nrst_o;
   logic        enable_pdid_o;
   logic        pdid_o;
   logic        enable_pdic_o;
   logic        pdic_o;

   logic [31:0] lcg_state = 32'd94;              // random generator state
   int          errors = 0;
   int          checks = 0;

   always #20 clk = ~clk;                        // 40 unit period

   cw_io_top DUT (.*);

   // all stimulus changes 5 units after the rising edge
   task automatic next_slot();
      @(posedge clk);
      #5;
   endtask

   function automatic reg_byte_t lcg_byte();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];                   // middle bits, low bits cycle too fast
   endfunction

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // one write strobe, accepted at the next edge
   task automatic do_write(input reg_addr_t addr, input byte_cnt_t cnt, input reg_byte_t data);
      addr_i      = addr;
      byte_cnt_i  = cnt;
      data_i      = data;
      reg_write_i = 1'b1;
      next_slot();
      reg_write_i = 1'b0;
   endtask

   // read strobe for one cycle, data_o taken in the following cycle
   task automatic do_read(input reg_addr_t addr, input byte_cnt_t cnt, input logic valid,
                          output reg_byte_t data);
      addr_i       = addr;
      byte_cnt_i   = cnt;
      addr_valid_i = valid;
      reg_read_i   = 1'b1;
      next_slot();
      data         = data_o;
      reg_read_i   = 1'b0;
      addr_valid_i = 1'b0;
   endtask

   task automatic report_test(input string name, input int err0);
      $display("test %0s done, %0d errors", name, errors - err0);
   endtask

   `include "tb_cw_io_tests.svh"

   initial begin
      reset             = 1'b1;
      addr_i            = '0;
      byte_cnt_i        = '0;
      data_i            = '0;
      reg_read_i        = 1'b0;
      reg_write_i       = 1'b0;
      addr_valid_i      = 1'b0;
      hyp_addr_i        = '0;
      trig_in_i         = '0;
      trig_advio_i      = 1'b0;
      trig_anapattern_i = 1'b0;
      trig_decodedio_i  = 1'b0;
      uart_tx_i         = 1'b0;                  // pin 1 drives tx after reset, keep it low
      usi_out_i         = 1'b0;
      targetio_i        = '0;
      repeat (5) @(posedge clk);
      #5;
      reset = 1'b0;
      test_reset_values();
      test_register_readback();
      test_trigger_combine();
      test_pin_drive();
      test_input_routing();
      test_power_off();
      $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // watchdog, budget covers every test with margin
   initial begin
      #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
      $display("timeout: the tests did not complete within %0d time units",
               NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
      $display("Finished with errors");
      $finish;
   end

endmodule
